// File: adc_select.sv
`timescale 1ns/1ps

`include "adcp_defs.svh"

module adc_select (
    input  logic                 axis_clk,
    input  logic                 reset,
    input  adcp_pkg::adc_sel_t   adc_sel,
    input  logic [`ADCP_N_ADC-1:0] adc_valid,
    input  adcp_pkg::iq_sample_t adc_data [`ADCP_N_ADC],
    output logic                 sel_valid,
    output adcp_pkg::iq_sample_t sel_data
);

    import adcp_pkg::*;

    // combinational pick of one stream
    logic       mux_valid;
    iq_sample_t mux_data;

    // no ready goes back toward the adcs
    // the adc tiles cannot be stalled, and one adc may feed several chains,
    // so a ready driven here could end up with more than one driver

    always_comb begin
        // stream 0 unless the index matches another stream
        // an out-of-range select therefore lands on stream 0
        mux_valid = adc_valid[0];
        mux_data  = adc_data[0];
        for (int k = 1; k < `ADCP_N_ADC; k++) begin
            if (adc_sel == adc_sel_t'(k)) begin
                mux_valid = adc_valid[k];
                mux_data  = adc_data[k];
            end
        end
    end

    // retime stage for the wide mux
    // valid is control state and clears on reset
    always_ff @(posedge axis_clk) begin
        if (reset) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= mux_valid;
        end
    end

    // payload just follows the mux, {q,i} kept as one word
    always_ff @(posedge axis_clk) begin
        sel_data <= mux_data;
    end

endmodule

// File: adcp_checker.sv
`timescale 1ns/1ps

`include "adcp_defs.svh"

module adcp_checker (
    input logic                 axis_clk,
    input logic                 reset,
    input logic                 dfe_credit,
    input logic                 dfe_valid,
    input adcp_pkg::iq_sample_t dfe_data,
    input logic [15:0]          overflow_count
);

    import adcp_pkg::*;

    // samples on the link not yet paid back by a credit pulse
    int outstanding;

    always_ff @(posedge axis_clk) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(dfe_valid) - int'(dfe_credit);
        end
    end

    // output idle in the cycle after reset and at its release
    reset_clears_valid: assert property (@(posedge axis_clk) reset |=> !dfe_valid)
        else $error("dfe_valid high right after reset");

    release_valid_low: assert property (@(posedge axis_clk) $fell(reset) |-> !dfe_valid)
        else $error("dfe_valid high as reset is released");

    // dfe receive slots never overrun
    credit_bound: assert property (
        @(posedge axis_clk) disable iff (reset)
        outstanding <= `ADCP_CREDIT_INIT
    ) else $error("more samples outstanding than dfe slots: %0d", outstanding);

    valid_data_known: assert property (
        @(posedge axis_clk) disable iff (reset)
        dfe_valid |-> !$isunknown(dfe_data)
    ) else $error("dfe_data has unknown bits while dfe_valid is high");

    // first cycle out of reset compares against the pre-reset value, so skip it
    overflow_monotonic: assert property (
        @(posedge axis_clk) disable iff (reset)
        !$past(reset) |-> (overflow_count >= $past(overflow_count))
    ) else $error("overflow_count decreased outside reset");

endmodule

// File: adcp_defs.svh
`ifndef ADCP_DEFS_SVH
`define ADCP_DEFS_SVH

// capture front end sizing

// adc streams offered to the selector
`define ADCP_N_ADC       8

// bits per i or q component, signed
`define ADCP_IQ_W        16

// gain fraction bits, Q1.14 with sign
`define ADCP_GAIN_FRAC   14

// sample fifo entries ahead of the dfe link
`define ADCP_BUF_DEPTH   16

// dfe receive slots, i.e. credits held after reset
`define ADCP_CREDIT_INIT 8

`endif

// File: adcp_pkg.sv
`include "adcp_defs.svh"

package adcp_pkg;

    // one complex sample as the adc tiles pack it
    // q sits in the upper half, i in the lower half
    typedef struct packed {
        logic signed [`ADCP_IQ_W-1:0] q;
        logic signed [`ADCP_IQ_W-1:0] i;
    } iq_sample_t;

    // stream index, just wide enough for all adc streams
    typedef logic [$clog2(`ADCP_N_ADC)-1:0] adc_sel_t;

    // signed gain, one integer bit plus sign above the fraction
    // 16 bits for Q1.14
    typedef logic signed [`ADCP_GAIN_FRAC+1:0] gain_t;

endpackage

// File: adcp_tb.sv
`timescale 1ns/1ps

`include "adcp_defs.svh"

module adcp_tb;

    import adcp_pkg::*;

    logic                   axis_clk = 1'b0;
    logic                   reset;
    adc_sel_t               adc_sel;
    gain_t                  gain;
    logic [`ADCP_N_ADC-1:0] adc_valid;
    iq_sample_t             adc_data [`ADCP_N_ADC];
    logic                   dfe_credit;
    logic                   dfe_valid;
    iq_sample_t             dfe_data;
    logic [15:0]            overflow_count;

    // expected dfe samples in arrival order
    iq_sample_t exp_q[$];

    int  check_errors;
    int  timeout_errors;
    int  pushed;
    int  delivered;
    int  skipped;
    int  owed;
    int  stream_cnt [`ADCP_N_ADC];
    bit  stream_on;
    bit  extreme;
    bit  withhold;

    always #4 axis_clk = ~axis_clk;

    adcp_top dut0 (
        .axis_clk       (axis_clk),
        .reset          (reset),
        .adc_sel        (adc_sel),
        .gain           (gain),
        .adc_valid      (adc_valid),
        .adc_data       (adc_data),
        .dfe_credit     (dfe_credit),
        .dfe_valid      (dfe_valid),
        .dfe_data       (dfe_data),
        .overflow_count (overflow_count)
    );

    bind adcp_top adcp_checker chk0 (.*);

    // x * g, add half lsb, floor shift, clamp to 16 bits
    function automatic logic signed [15:0] scale_component(
        input logic signed [15:0] x,
        input gain_t              g
    );
        longint p;
        p = longint'(x) * longint'(g);
        p = (p + (64'sd1 <<< (`ADCP_GAIN_FRAC - 1))) >>> `ADCP_GAIN_FRAC;
        if (p > 64'sd32767) begin
            p = 64'sd32767;
        end else if (p < -64'sd32768) begin
            p = -64'sd32768;
        end
        return p[15:0];
    endfunction

    function automatic logic signed [15:0] pick_extreme();
        int r;
        r = int'($urandom % 3);
        if (r == 0) begin
            return 16'sh7fff;
        end else if (r == 1) begin
            return 16'sh8000;
        end
        return 16'($urandom);
    endfunction

    // adc models put the stream index in the top bits of i and a running count below
    always @(posedge axis_clk) begin
        #1;
        for (int k = 0; k < `ADCP_N_ADC; k++) begin
            adc_valid[k] = stream_on && (($urandom % 4) != 0);
            if (extreme) begin
                adc_data[k].i = pick_extreme();
                adc_data[k].q = pick_extreme();
            end else begin
                adc_data[k].i = {3'(k), 13'(stream_cnt[k])};
                adc_data[k].q = 16'($urandom);
            end
            if (adc_valid[k]) begin
                stream_cnt[k]++;
            end
        end
    end

    // reference model at the adc ports
    always @(negedge axis_clk) begin
        iq_sample_t e;
        if (!reset && adc_valid[adc_sel]) begin
            e.i = scale_component(adc_data[adc_sel].i, gain);
            e.q = scale_component(adc_data[adc_sel].q, gain);
            exp_q.push_back(e);
            pushed++;
        end
    end

    // sink model samples mid cycle where outputs are settled
    always @(negedge axis_clk) begin
        iq_sample_t head;
        if (!reset && dfe_valid) begin
            owed++;
            delivered++;
            // only a counted drop may leave a gap in the expected order
            while (exp_q.size() != 0 && exp_q[0] != dfe_data &&
                   skipped < int'(overflow_count)) begin
                void'(exp_q.pop_front());
                skipped++;
            end
            head = (exp_q.size() != 0) ? exp_q[0] : '0;
            assert (exp_q.size() != 0 && head == dfe_data) else begin
                check_errors++;
                $display("CHECK FAILED dfe_data expected %h actual %h", head, dfe_data);
            end
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
        end
    end

    // credit return after a random delay
    always @(posedge axis_clk) begin
        #1;
        dfe_credit = 1'b0;
        if (!reset && !withhold && owed > 0 && ($urandom % 3) != 0) begin
            dfe_credit = 1'b1;
            owed--;
        end
    end

    task automatic run_stream(input int cycles);
        @(posedge axis_clk);
        stream_on = 1'b1;
        repeat (cycles) @(posedge axis_clk);
        stream_on = 1'b0;
    endtask

    // idle means 30 quiet cycles on both ports with every credit returned
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        for (int n = 0; n < 3000 && quiet < 30; n++) begin
            @(negedge axis_clk);
            quiet = (dfe_valid || adc_valid != '0 || owed != 0) ? 0 : quiet + 1;
        end
        if (quiet < 30) begin
            timeout_errors++;
            $display("timeout: the dfe output never went idle");
        end
    endtask

    task automatic wait_delivered(input int target);
        int n;
        for (n = 0; n < 2000 && delivered < target; n++) begin
            @(negedge axis_clk);
        end
        if (delivered < target) begin
            timeout_errors++;
            $display("timeout: only %0d of %0d samples reached the dfe", delivered, target);
        end
    endtask

    task automatic check_totals(input bit no_drops);
        assert (pushed == delivered + int'(overflow_count)) else begin
            check_errors++;
            $display("CHECK FAILED overflow_count expected %h actual %h",
                     pushed - delivered, overflow_count);
        end
        if (no_drops) begin
            assert (overflow_count == 16'h0) else begin
                check_errors++;
                $display("CHECK FAILED overflow_count expected %h actual %h",
                         16'h0, overflow_count);
            end
        end
    endtask

    // with credits held back exactly one window of samples gets through
    task automatic credit_window(input int base);
        withhold = 1'b1;
        run_stream(20);
        wait_delivered(base + `ADCP_CREDIT_INIT);
        repeat (40) @(negedge axis_clk);
        assert (delivered == base + `ADCP_CREDIT_INIT) else begin
            check_errors++;
            $display("CHECK FAILED dfe_valid count expected %h actual %h",
                     base + `ADCP_CREDIT_INIT, delivered);
        end
        withhold = 1'b0;
        wait_idle();
    endtask

    task automatic set_gain(input gain_t g);
        @(posedge axis_clk);
        #1;
        gain = g;
    endtask

    initial begin
        gain_t gains [4];
        void'($urandom(38613));
        gains[0] = 16'sd16384;
        gains[1] = 16'sd8192;
        gains[2] = -16'sd16384;
        gains[3] = 16'sd32767;
        reset      = 1'b1;
        adc_sel    = '0;
        gain       = 16'sd16384;
        adc_valid  = '0;
        dfe_credit = 1'b0;
        for (int k = 0; k < `ADCP_N_ADC; k++) begin
            adc_data[k]   = '0;
            stream_cnt[k] = 0;
        end
        repeat (5) @(posedge axis_clk);
        #1;
        reset = 1'b0;

        // selection of every stream at unity gain with credits flowing
        for (int s = 0; s < `ADCP_N_ADC; s++) begin
            @(posedge axis_clk);
            #1;
            adc_sel = adc_sel_t'(s);
            run_stream(30);
            wait_idle();
            check_totals(1'b1);
        end

        // each gain gets normal inputs and then extreme ones that saturate
        for (int g = 0; g < 4; g++) begin
            set_gain(gains[g]);
            extreme = 1'b0;
            run_stream(25);
            wait_idle();
            extreme = 1'b1;
            run_stream(25);
            wait_idle();
            extreme = 1'b0;
            check_totals(1'b1);
        end
        set_gain(16'sd16384);

        credit_window(delivered);
        check_totals(1'b1);

        // fifo overflow while credits are withheld
        withhold = 1'b1;
        run_stream(80);
        repeat (10) @(negedge axis_clk);
        assert (overflow_count != 16'h0) else begin
            check_errors++;
            $display("the fifo never overflowed while credits were withheld");
        end
        withhold = 1'b0;
        wait_idle();
        check_totals(1'b0);

        // reset in the middle of traffic
        @(posedge axis_clk);
        stream_on = 1'b1;
        repeat (10) @(posedge axis_clk);
        #1;
        reset = 1'b1;
        stream_on = 1'b0;
        repeat (3) @(negedge axis_clk);
        assert (!dfe_valid && overflow_count == 16'h0) else begin
            check_errors++;
            $display("CHECK FAILED dfe_valid/overflow_count expected %h actual %h",
                     17'h0, {dfe_valid, overflow_count});
        end
        exp_q.delete();
        pushed    = 0;
        delivered = 0;
        skipped   = 0;
        owed      = 0;
        @(posedge axis_clk);
        #1;
        reset = 1'b0;
        credit_window(0);
        check_totals(1'b1);

        $display("check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: adcp_top.sv
`timescale 1ns/1ps

`include "adcp_defs.svh"

module adcp_top (
    input  logic                   axis_clk,
    input  logic                   reset,
    // stream select and complex gain, static in normal use
    input  adcp_pkg::adc_sel_t     adc_sel,
    input  adcp_pkg::gain_t        gain,
    // adc side, no ready
    input  logic [`ADCP_N_ADC-1:0] adc_valid,
    input  adcp_pkg::iq_sample_t   adc_data [`ADCP_N_ADC],
    // dfe side, credit flow control
    input  logic                   dfe_credit,
    output logic                   dfe_valid,
    output adcp_pkg::iq_sample_t   dfe_data,
    output logic [15:0]            overflow_count
);

    import adcp_pkg::*;

    // selector to gain
    logic       sel_valid;
    iq_sample_t sel_data;

    // gain to buffer
    logic       scl_valid;
    iq_sample_t scl_data;

    // one cycle: pick and retime
    adc_select u_adc_select (
        .axis_clk  (axis_clk),
        .reset     (reset),
        .adc_sel   (adc_sel),
        .adc_valid (adc_valid),
        .adc_data  (adc_data),
        .sel_valid (sel_valid),
        .sel_data  (sel_data)
    );

    // two cycles: multiply, then round and clamp
    iq_gain_scale u_iq_gain_scale (
        .axis_clk  (axis_clk),
        .reset     (reset),
        .gain      (gain),
        .sel_valid (sel_valid),
        .sel_data  (sel_data),
        .scl_valid (scl_valid),
        .scl_data  (scl_data)
    );

    // one cycle when empty with credit, otherwise queued
    // a full fifo drops and counts
    credit_tx_buffer u_credit_tx_buffer (
        .axis_clk       (axis_clk),
        .reset          (reset),
        .scl_valid      (scl_valid),
        .scl_data       (scl_data),
        .dfe_credit     (dfe_credit),
        .dfe_valid      (dfe_valid),
        .dfe_data       (dfe_data),
        .overflow_count (overflow_count)
    );

endmodule

// File: credit_tx_buffer.sv
`timescale 1ns/1ps

`include "adcp_defs.svh"

module credit_tx_buffer (
    input  logic                 axis_clk,
    input  logic                 reset,
    input  logic                 scl_valid,
    input  adcp_pkg::iq_sample_t scl_data,
    input  logic                 dfe_credit,
    output logic                 dfe_valid,
    output adcp_pkg::iq_sample_t dfe_data,
    output logic [15:0]          overflow_count
);

    import adcp_pkg::*;

    localparam int DEPTH  = `ADCP_BUF_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`ADCP_CREDIT_INIT + 1);

    localparam logic [PTR_W-1:0]  LAST_PTR    = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0]  FULL_LVL    = CNT_W'(DEPTH);
    localparam logic [CRED_W-1:0] CREDIT_INIT = CRED_W'(`ADCP_CREDIT_INIT);

    // sample storage
    iq_sample_t        fifo_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fill_cnt;

    // credits still held toward the dfe
    logic [CRED_W-1:0] credit_cnt;

    logic fifo_empty;
    logic fifo_full;
    logic credit_ok;
    logic bypass;
    logic wr_en;
    logic rd_en;
    logic send;
    logic drop;

    assign fifo_empty = (fill_cnt == '0);
    assign fifo_full  = (fill_cnt == FULL_LVL);

    // a credit arriving this cycle already counts for this decision
    assign credit_ok  = (credit_cnt != '0) || dfe_credit;

    // empty fifo with credit: sample goes straight to the output register
    // keeps the one cycle latency and cannot reorder anything
    assign bypass = scl_valid && fifo_empty && credit_ok;
    assign rd_en  = !fifo_empty && credit_ok;
    assign send   = bypass || rd_en;

    // everything else queues, or is lost when the fifo is full
    assign wr_en  = scl_valid && !bypass && !fifo_full;
    assign drop   = scl_valid && !bypass && fifo_full;

    // pointers, occupancy
    always_ff @(posedge axis_clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            fifo_mem[wr_ptr] <= scl_data;
        end
    end

    // spend one per sample sent, regain one per returned pulse
    // both at once leaves the count alone
    always_ff @(posedge axis_clk) begin
        if (reset) begin
            credit_cnt <= CREDIT_INIT;
        end else begin
            case ({send, dfe_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // registered dfe output, one valid cycle per sample
    always_ff @(posedge axis_clk) begin
        if (reset) begin
            dfe_valid <= 1'b0;
        end else begin
            dfe_valid <= send;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (send) begin
            dfe_data <= bypass ? scl_data : fifo_mem[rd_ptr];
        end
    end

    // dropped samples, sticks at all ones
    always_ff @(posedge axis_clk) begin
        if (reset) begin
            overflow_count <= '0;
        end else if (drop && (overflow_count != '1)) begin
            overflow_count <= overflow_count + 1'b1;
        end
    end

endmodule

// File: iq_gain_scale.sv
`timescale 1ns/1ps

`include "adcp_defs.svh"

module iq_gain_scale (
    input  logic                 axis_clk,
    input  logic                 reset,
    input  adcp_pkg::gain_t      gain,
    input  logic                 sel_valid,
    input  adcp_pkg::iq_sample_t sel_data,
    output logic                 scl_valid,
    output adcp_pkg::iq_sample_t scl_data
);

    import adcp_pkg::*;

    localparam int IQ_W   = `ADCP_IQ_W;
    localparam int FRAC   = `ADCP_GAIN_FRAC;
    localparam int PROD_W = 2 * IQ_W;
    // product after the shift, one guard bit for the rounding add
    localparam int SH_W   = PROD_W + 1 - FRAC;

    // half an lsb of the result, in product units
    localparam logic signed [PROD_W:0] HALF_LSB = (PROD_W + 1)'(1 << (FRAC - 1));

    // clamp limits at the shifted width
    localparam logic signed [SH_W-1:0] SAT_MAX =
        {{(SH_W - IQ_W + 1){1'b0}}, {(IQ_W - 1){1'b1}}};
    localparam logic signed [SH_W-1:0] SAT_MIN =
        {{(SH_W - IQ_W + 1){1'b1}}, {(IQ_W - 1){1'b0}}};

    // stage one state
    logic                     s1_valid;
    logic signed [PROD_W-1:0] prod_i;
    logic signed [PROD_W-1:0] prod_q;

    // round half up, drop fraction, clamp to the component range
    function automatic logic signed [IQ_W-1:0] round_sat(
        input logic signed [PROD_W-1:0] prod
    );
        logic signed [PROD_W:0] ext;
        logic signed [PROD_W:0] sum;
        logic signed [SH_W-1:0] shifted;
        ext = prod;
        sum = ext + HALF_LSB;
        // upper bits are the floor of sum / 2^FRAC
        shifted = sum[PROD_W:FRAC];
        if (shifted > SAT_MAX) begin
            return SAT_MAX[IQ_W-1:0];
        end else if (shifted < SAT_MIN) begin
            return SAT_MIN[IQ_W-1:0];
        end
        return shifted[IQ_W-1:0];
    endfunction

    // valid runs alongside the two data stages
    always_ff @(posedge axis_clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            scl_valid <= 1'b0;
        end else begin
            s1_valid  <= sel_valid;
            scl_valid <= s1_valid;
        end
    end

    // stage one: full-width products
    // gain sampled in the same cycle as the sample
    always_ff @(posedge axis_clk) begin
        prod_i <= sel_data.i * gain;
        prod_q <= sel_data.q * gain;
    end

    // stage two: rounding and saturation per component
    always_ff @(posedge axis_clk) begin
        scl_data.i <= round_sat(prod_i);
        scl_data.q <= round_sat(prod_q);
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the capture front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module adcp_tb \
    -f tb.f \
    -o adcp_sim

out=$(./obj_dir/adcp_sim 2>&1) || {
    echo "$out"
    exit 1
}
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb.f
+incdir+.
adcp_pkg.sv
adc_select.sv
iq_gain_scale.sv
credit_tx_buffer.sv
adcp_top.sv
adcp_checker.sv
adcp_tb.sv
